// ==== build.f ====
sad_pkg.sv
sad_lane_if.sv
sad_regs.sv
sad_ref_feeder.sv
sad_lane.sv
sad_trigger_collect.sv
sad_trigger.sv
tb_sad_trigger.sv

// ==== Bender.yml ====
package:
  name: sad_trigger

sources:
  - sad_pkg.sv
  - sad_lane_if.sv
  - sad_regs.sv
  - sad_ref_feeder.sv
  - sad_lane.sv
  - sad_trigger_collect.sv
  - sad_trigger.sv
  - target: test
    files:
      - tb_sad_trigger.sv

// ==== tb_sad_trigger.sv ====
`timescale 1ns/1ps

module tb_sad_trigger;

    localparam int N      = 16;  // reference length
    localparam int PERIOD = 10;
    localparam int FILL   = 20;  // random samples ahead of a pattern
    // nine streams at most, register traffic stays well under 400 cycles
    localparam int STREAM_CYCLES  = FILL + 3 * N + 8 + 6;
    localparam int TIMEOUT_CYCLES = 9 * STREAM_CYCLES + 400;

    logic              adc_sampleclk = 1'b0;
    logic              reset         = 1'b1;
    sad_pkg::sample_t  adc_datain    = '0;
    logic              armed         = 1'b0;
    logic              active        = 1'b0;
    logic              xadc_error    = 1'b0;
    sad_pkg::addr_t    reg_address   = '0;
    sad_pkg::bytecnt_t reg_bytecnt   = '0;
    logic [7:0]        reg_datai     = '0;
    logic              reg_read      = 1'b0;
    logic              reg_write     = 1'b0;
    logic [7:0]        reg_datao;
    logic              trigger;

    // model of the register contents and the status
    int               seed = 19277;
    sad_pkg::sample_t ref_pat [N];
    logic [N-1:0]     mask          = '1;
    int               thr           = 0;
    logic             multi         = 1'b0;
    logic             exp_triggered = 1'b0;
    int               exp_count     = 0;

    sad_trigger #(.REF_SAMPLES(N)) u_sad_trigger (.*);

    initial begin
        forever #(PERIOD / 2) adc_sampleclk = ~adc_sampleclk;
    end

    initial begin
        #(TIMEOUT_CYCLES * PERIOD);
        $display("timeout, the tests were still running after %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

    task automatic report_error(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic write_reg(input sad_pkg::addr_t addr, input int bc, input logic [7:0] data);
        @(posedge adc_sampleclk);
        reg_address <= addr;
        reg_bytecnt <= sad_pkg::bytecnt_t'(bc);
        reg_datai   <= data;
        reg_write   <= 1'b1;
        @(posedge adc_sampleclk);
        reg_write <= 1'b0;
    endtask

    // little endian, byte 0 first
    task automatic write_pair(input sad_pkg::addr_t addr, input logic [15:0] value);
        write_reg(addr, 0, value[7:0]);
        write_reg(addr, 1, value[15:8]);
    endtask

    task automatic expect_reg(input sad_pkg::addr_t addr, input int bc, input logic [7:0] exp);
        @(posedge adc_sampleclk);
        reg_address <= addr;
        reg_bytecnt <= sad_pkg::bytecnt_t'(bc);
        reg_read    <= 1'b1;
        @(negedge adc_sampleclk);
        assert (reg_datao === exp) else
            report_error($sformatf("register %h byte %0d read %h, expected %h",
                                   addr, bc, reg_datao, exp));
        @(posedge adc_sampleclk);
        reg_read <= 1'b0;
    endtask

    task automatic expect_status();
        expect_reg(sad_pkg::ADDR_STATUS, 0, {7'b0, exp_triggered});
        expect_reg(sad_pkg::ADDR_STATUS, 1, exp_count[7:0]);
        expect_reg(sad_pkg::ADDR_STATUS, 2, exp_count[15:8]);
    endtask

    task automatic clear_by_write();
        write_reg(sad_pkg::ADDR_STATUS, 0, 8'h00);
        exp_triggered = 1'b0;
        exp_count     = 0;
    endtask

    task automatic rearm();
        @(posedge adc_sampleclk);
        armed <= 1'b0;
        @(posedge adc_sampleclk);
        armed <= 1'b1;  // rising edge clears the status
        exp_triggered = 1'b0;
        exp_count     = 0;
    endtask

    // SAD of the window ending at s[last] against the reference
    function automatic int model_sad(input sad_pkg::sample_t s[$], input int last);
        int sum;
        int d;
        sum = 0;
        for (int k = 0; k < N; k++) begin
            d = int'(s[last - N + 1 + k]) - int'(ref_pat[k]);
            if (d < 0)
                d = -d;
            if (!mask[k])
                d = 0;  // entry not compared
            if (sum < (1 << (sad_pkg::SAD_BITS - 1)))
                sum += d;  // stops counting once the MSB is set
        end
        return sum;
    endfunction

    function automatic void append_random(ref sad_pkg::sample_t q[$], input int n);
        for (int k = 0; k < n; k++)
            q.push_back(sad_pkg::sample_t'($random(seed)));
    endfunction

    // copy of the reference, entries in sel shifted by delta without wrapping
    function automatic void push_pattern(ref sad_pkg::sample_t q[$], input int delta,
                                         input logic [N-1:0] sel);
        for (int k = 0; k < N; k++) begin
            if (!sel[k])
                q.push_back(ref_pat[k]);
            else if (ref_pat[k] < 128)
                q.push_back(ref_pat[k] + sad_pkg::sample_t'(delta));
            else
                q.push_back(ref_pat[k] - sad_pkg::sample_t'(delta));
        end
    endfunction

    // sample driven at edge k is captured at k+1, its trigger is due at edge k+5
    task automatic stream(input sad_pkg::sample_t s[$]);
        logic exp_trig [$];
        logic hit;
        @(negedge adc_sampleclk);  // run inputs settled
        for (int j = 0; j < s.size(); j++) begin
            hit = armed && active && !xadc_error && j >= N - 1 && model_sad(s, j) <= thr;
            exp_trig.push_back(hit && !(exp_triggered && !multi));
            if (exp_trig[j]) begin
                exp_triggered = 1'b1;
                exp_count++;
            end
        end
        for (int k = 0; k < s.size() + 5; k++) begin
            @(posedge adc_sampleclk);
            if (k < s.size())
                adc_datain <= s[k];
            @(negedge adc_sampleclk);
            if (k >= 5) begin
                assert (trigger === exp_trig[k - 5]) else
                    report_error($sformatf("trigger %b after sample %0d, expected %b",
                                           trigger, k - 5, exp_trig[k - 5]));
            end
        end
    endtask

    task automatic register_access();
        expect_status();  // reset values
        expect_reg(sad_pkg::ADDR_REFEN, 0, 8'hFF);
        for (int k = 0; k < N; k++) begin
            ref_pat[k] = sad_pkg::sample_t'($random(seed));
            write_reg(sad_pkg::ADDR_REFERENCE, k, ref_pat[k]);
        end
        write_pair(sad_pkg::ADDR_REFEN, 16'hA5C3);
        write_pair(sad_pkg::ADDR_THRESHOLD, 16'd11);
        thr = 11;
        write_reg(sad_pkg::ADDR_MULTIPLE_TRIGGERS, 0, 8'h01);
        for (int k = 0; k < N; k++)
            expect_reg(sad_pkg::ADDR_REFERENCE, k, ref_pat[k]);
        expect_reg(sad_pkg::ADDR_REFEN, 0, 8'hC3);
        expect_reg(sad_pkg::ADDR_REFEN, 1, 8'hA5);
        expect_reg(sad_pkg::ADDR_THRESHOLD, 0, 8'd11);
        expect_reg(sad_pkg::ADDR_THRESHOLD, 1, 8'd0);
        expect_reg(sad_pkg::ADDR_MULTIPLE_TRIGGERS, 0, 8'h01);
        @(negedge adc_sampleclk);
        assert (reg_datao === 8'h00) else
            report_error($sformatf("reg_datao %h while reg_read is low", reg_datao));
        write_pair(sad_pkg::ADDR_REFEN, 16'hFFFF);
        write_reg(sad_pkg::ADDR_MULTIPLE_TRIGGERS, 0, 8'h00);
    endtask

    task automatic exact_match();
        sad_pkg::sample_t q[$];
        @(posedge adc_sampleclk);
        active <= 1'b1;
        rearm();
        append_random(q, FILL);
        push_pattern(q, 0, '0);
        append_random(q, 8);
        stream(q);
        expect_status();
    endtask

    task automatic threshold_and_mask();
        sad_pkg::sample_t q[$];
        sad_pkg::sample_t big[$];
        clear_by_write();
        append_random(q, FILL);
        push_pattern(q, 4, 16'h0224);  // three entries off by 4, SAD one over 11
        append_random(q, 8);
        stream(q);
        write_pair(sad_pkg::ADDR_REFEN, ~16'h0224);
        mask = ~16'h0224;
        stream(q);
        expect_status();
        write_pair(sad_pkg::ADDR_REFEN, 16'hFFFF);
        mask = '1;
        clear_by_write();
        append_random(big, FILL);
        push_pattern(big, 127, '1);
        append_random(big, 8);
        stream(big);
        expect_status();
    endtask

    task automatic repeated_windows();
        sad_pkg::sample_t q[$];
        clear_by_write();
        append_random(q, FILL);
        repeat (3)
            push_pattern(q, 0, '0);
        append_random(q, 8);
        stream(q);  // one shot
        expect_status();
        write_reg(sad_pkg::ADDR_MULTIPLE_TRIGGERS, 0, 8'h01);
        multi = 1'b1;
        stream(q);
        expect_status();
        clear_by_write();
        expect_status();
        write_reg(sad_pkg::ADDR_MULTIPLE_TRIGGERS, 0, 8'h00);
        multi = 1'b0;
    endtask

    task automatic run_gating();
        sad_pkg::sample_t q[$];
        append_random(q, FILL);
        push_pattern(q, 0, '0);
        append_random(q, 8);
        @(posedge adc_sampleclk);
        active <= 1'b0;
        stream(q);
        @(posedge adc_sampleclk);
        active     <= 1'b1;
        xadc_error <= 1'b1;
        stream(q);
        @(posedge adc_sampleclk);
        xadc_error <= 1'b0;
        stream(q);
        expect_status();
        rearm();
        expect_status();
    endtask

    initial begin
        repeat (4) @(posedge adc_sampleclk);
        reset <= 1'b0;
        register_access();
        exact_match();
        threshold_and_mask();
        repeated_windows();
        run_gating();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== sad_trigger.sv ====
`timescale 1ns/1ps

module sad_trigger #(
    parameter int REF_SAMPLES = 16  // power of two, at least 4
) (
    input  logic              adc_sampleclk,
    input  logic              reset,
    input  sad_pkg::sample_t  adc_datain,
    input  logic              armed,
    input  logic              active,
    input  logic              xadc_error,
    input  sad_pkg::addr_t    reg_address,
    input  sad_pkg::bytecnt_t reg_bytecnt,
    input  logic [7:0]        reg_datai,
    input  logic              reg_read,
    input  logic              reg_write,
    output logic [7:0]        reg_datao,
    output logic              trigger
);

    sad_pkg::sample_t [REF_SAMPLES-1:0] ref_samples;
    logic [REF_SAMPLES-1:0]             ref_en;
    sad_pkg::sad_count_t                threshold;
    logic                               multiple_triggers;
    logic                               clear_status;
    logic                               triggered;
    sad_pkg::trig_count_t               trig_count;
    sad_pkg::sample_t                   sample;
    logic [REF_SAMPLES-1:0]             hit;

    // element 0 from the feeder, last one dangles
    sad_lane_if chain [0:REF_SAMPLES] ();

    sad_regs #(
        .REF_SAMPLES(REF_SAMPLES)
    ) u_sad_regs (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .reg_address      (reg_address),
        .reg_bytecnt      (reg_bytecnt),
        .reg_datai        (reg_datai),
        .reg_read         (reg_read),
        .reg_write        (reg_write),
        .reg_datao        (reg_datao),
        .ref_samples      (ref_samples),
        .ref_en           (ref_en),
        .threshold        (threshold),
        .multiple_triggers(multiple_triggers),
        .clear_status     (clear_status),
        .triggered        (triggered),
        .trig_count       (trig_count)
    );

    sad_ref_feeder #(
        .REF_SAMPLES(REF_SAMPLES)
    ) u_sad_ref_feeder (
        .adc_sampleclk(adc_sampleclk),
        .reset        (reset),
        .adc_datain   (adc_datain),
        .armed        (armed),
        .active       (active),
        .xadc_error   (xadc_error),
        .ref_samples  (ref_samples),
        .ref_en       (ref_en),
        .sample       (sample),
        .chain        (chain[0])
    );

    for (genvar i = 0; i < REF_SAMPLES; i++) begin : gen_lane
        sad_lane u_sad_lane (
            .adc_sampleclk(adc_sampleclk),
            .reset        (reset),
            .sample       (sample),
            .threshold    (threshold),
            .up           (chain[i]),
            .down         (chain[i+1]),
            .hit          (hit[i])
        );
    end

    sad_trigger_collect #(
        .REF_SAMPLES(REF_SAMPLES)
    ) u_sad_trigger_collect (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .hit              (hit),
        .armed            (armed),
        .multiple_triggers(multiple_triggers),
        .clear_status     (clear_status),
        .trigger          (trigger),
        .triggered        (triggered),
        .trig_count       (trig_count)
    );

endmodule

// ==== sad_trigger_collect.sv ====
`timescale 1ns/1ps

module sad_trigger_collect #(
    parameter int REF_SAMPLES = 16
) (
    input  logic                   adc_sampleclk,
    input  logic                   reset,
    input  logic [REF_SAMPLES-1:0] hit,
    input  logic                   armed,
    input  logic                   multiple_triggers,
    input  logic                   clear_status,
    output logic                   trigger,
    output logic                   triggered,
    output sad_pkg::trig_count_t   trig_count
);

    logic armed_r;
    logic fire;

    // one shot unless multiple triggers allowed
    assign fire = (|hit) && !(triggered && !multiple_triggers);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            armed_r    <= 1'b0;
            trigger    <= 1'b0;
            triggered  <= 1'b0;
            trig_count <= '0;
        end else begin
            armed_r <= armed;
            trigger <= fire;
            if (clear_status || (armed && !armed_r)) begin  // re-arm clears status too
                triggered  <= 1'b0;
                trig_count <= '0;
            end else if (fire) begin
                triggered  <= 1'b1;
                trig_count <= trig_count + 1'b1;
            end
        end
    end

endmodule

// ==== sad_lane.sv ====
`timescale 1ns/1ps

module sad_lane (
    input  logic                adc_sampleclk,
    input  logic                reset,
    input  sad_pkg::sample_t    sample,
    input  sad_pkg::sad_count_t threshold,
    sad_lane_if.down            up,
    sad_lane_if.up              down,
    output logic                hit
);

    sad_pkg::sample_t    diff;        // |sample - ref|, zero when masked
    logic                diff_start;  // diff belongs to index 0
    logic                win_ok;      // window started with run high, no gap since
    logic                complete;    // acc holds a full window
    sad_pkg::sad_count_t acc;

    // payload path, passed on unchanged
    always_ff @(posedge adc_sampleclk) begin
        down.ref_sample <= up.ref_sample;
        down.ref_en     <= up.ref_en;
        if (!up.ref_en)
            diff <= '0;
        else if (sample > up.ref_sample)
            diff <= sample - up.ref_sample;
        else
            diff <= up.ref_sample - sample;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            down.window_start <= 1'b0;
            down.run          <= 1'b0;
            diff_start        <= 1'b0;
            win_ok            <= 1'b0;
            complete          <= 1'b0;
            acc               <= '0;
            hit               <= 1'b0;
        end else begin
            down.window_start <= up.window_start;
            down.run          <= up.run;
            diff_start        <= up.window_start;

            if (!up.run)
                win_ok <= 1'b0;  // drop partial window
            else if (up.window_start)
                win_ok <= 1'b1;

            // next index 0 with run still high closes the previous window
            complete <= up.run && up.window_start && win_ok;

            if (diff_start)
                acc <= sad_pkg::sad_count_t'(diff);
            else if (!acc[sad_pkg::SAD_BITS-1])  // hold once saturated
                acc <= acc + sad_pkg::sad_count_t'(diff);

            hit <= complete && (acc <= threshold);
        end
    end

endmodule

// ==== sad_ref_feeder.sv ====
`timescale 1ns/1ps

module sad_ref_feeder #(
    parameter int REF_SAMPLES = 16
) (
    input  logic                               adc_sampleclk,
    input  logic                               reset,
    input  sad_pkg::sample_t                   adc_datain,
    input  logic                               armed,
    input  logic                               active,
    input  logic                               xadc_error,
    input  sad_pkg::sample_t [REF_SAMPLES-1:0] ref_samples,
    input  logic [REF_SAMPLES-1:0]             ref_en,
    output sad_pkg::sample_t                   sample,
    sad_lane_if.up                             chain
);

    localparam int IDX_BITS = $clog2(REF_SAMPLES);

    logic                run;
    logic [IDX_BITS-1:0] index;  // reference entry offered to lane 0

    // sample register, shared by all lanes
    always_ff @(posedge adc_sampleclk) begin
        sample <= adc_datain;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            run   <= 1'b0;
            index <= '0;
        end else begin
            run <= armed && active && !xadc_error;
            if (!run)
                index <= '0;
            else
                index <= index + 1'b1;  // power-of-two size, wraps by itself
        end
    end

    // head of the chain, lane i sees this i cycles later
    assign chain.ref_sample   = ref_samples[index];
    assign chain.ref_en       = ref_en[index];
    assign chain.window_start = (index == '0);
    assign chain.run          = run;

endmodule

// ==== sad_regs.sv ====
`timescale 1ns/1ps

module sad_regs #(
    parameter int REF_SAMPLES = 16
) (
    input  logic                                     adc_sampleclk,
    input  logic                                     reset,
    input  sad_pkg::addr_t                           reg_address,
    input  sad_pkg::bytecnt_t                        reg_bytecnt,
    input  logic [7:0]                               reg_datai,
    input  logic                                     reg_read,
    input  logic                                     reg_write,
    output logic [7:0]                               reg_datao,
    output sad_pkg::sample_t [REF_SAMPLES-1:0]       ref_samples,
    output logic [REF_SAMPLES-1:0]                   ref_en,
    output sad_pkg::sad_count_t                      threshold,
    output logic                                     multiple_triggers,
    output logic                                     clear_status,
    input  logic                                     triggered,
    input  sad_pkg::trig_count_t                     trig_count
);

    localparam int REF_BITS    = REF_SAMPLES * sad_pkg::SAMPLE_BITS;
    localparam int REF_BYTES   = (REF_BITS + 7) / 8;
    localparam int MASK_BYTES  = (REF_SAMPLES + 7) / 8;
    localparam int THR_BYTES   = (sad_pkg::SAD_BITS + 7) / 8;
    localparam int STAT_BYTES  = 3;

    logic [REF_BYTES*8-1:0]  ref_bits;   // byte-padded storage
    logic [MASK_BYTES*8-1:0] mask_bits;
    logic [THR_BYTES*8-1:0]  thr_bits;
    logic [STAT_BYTES*8-1:0] status_bits;

    assign ref_samples = ref_bits[REF_BITS-1:0];
    assign ref_en      = mask_bits[REF_SAMPLES-1:0];
    assign threshold   = thr_bits[sad_pkg::SAD_BITS-1:0];
    assign status_bits = {trig_count, 7'b0, triggered};

    always_comb begin
        reg_datao = 8'h00;
        if (reg_read) begin
            case (reg_address)
                sad_pkg::ADDR_REFERENCE: begin
                    if (reg_bytecnt < REF_BYTES)
                        reg_datao = ref_bits[reg_bytecnt*8 +: 8];
                end
                sad_pkg::ADDR_REFEN: begin
                    if (reg_bytecnt < MASK_BYTES)
                        reg_datao = mask_bits[reg_bytecnt*8 +: 8];
                end
                sad_pkg::ADDR_THRESHOLD: begin
                    if (reg_bytecnt < THR_BYTES)
                        reg_datao = thr_bits[reg_bytecnt*8 +: 8];
                end
                sad_pkg::ADDR_STATUS: begin
                    if (reg_bytecnt < STAT_BYTES)
                        reg_datao = status_bits[reg_bytecnt*8 +: 8];
                end
                sad_pkg::ADDR_MULTIPLE_TRIGGERS: reg_datao = {7'b0, multiple_triggers};
                default: reg_datao = 8'h00;
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            ref_bits          <= '0;
            mask_bits         <= '1;  // every entry compared by default
            thr_bits          <= '0;
            multiple_triggers <= 1'b0;
            clear_status      <= 1'b0;
        end else begin
            // any write to status clears it
            clear_status <= reg_write && (reg_address == sad_pkg::ADDR_STATUS);
            if (reg_write) begin
                case (reg_address)
                    sad_pkg::ADDR_REFERENCE: begin
                        if (reg_bytecnt < REF_BYTES)
                            ref_bits[reg_bytecnt*8 +: 8] <= reg_datai;
                    end
                    sad_pkg::ADDR_REFEN: begin
                        if (reg_bytecnt < MASK_BYTES)
                            mask_bits[reg_bytecnt*8 +: 8] <= reg_datai;
                    end
                    sad_pkg::ADDR_THRESHOLD: begin
                        if (reg_bytecnt < THR_BYTES)
                            thr_bits[reg_bytecnt*8 +: 8] <= reg_datai;
                    end
                    sad_pkg::ADDR_MULTIPLE_TRIGGERS: multiple_triggers <= reg_datai[0];
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== sad_lane_if.sv ====
`timescale 1ns/1ps

// one hop of the reference chain, advances every clock
interface sad_lane_if;

    sad_pkg::sample_t ref_sample;
    logic             ref_en;        // compare enable for this entry
    logic             window_start;  // entry is reference index 0
    logic             run;

    modport up (
        output ref_sample,
        output ref_en,
        output window_start,
        output run
    );

    modport down (
        input ref_sample,
        input ref_en,
        input window_start,
        input run
    );

endinterface

// ==== sad_pkg.sv ====
package sad_pkg;

    localparam int SAMPLE_BITS  = 8;   // ADC resolution
    localparam int SAD_BITS     = 16;  // accumulator width, MSB flags saturation
    localparam int BYTECNT_BITS = 7;   // register byte counter

    typedef logic [SAMPLE_BITS-1:0]  sample_t;
    typedef logic [SAD_BITS-1:0]     sad_count_t;
    typedef logic [15:0]             trig_count_t;
    typedef logic [7:0]              addr_t;
    typedef logic [BYTECNT_BITS-1:0] bytecnt_t;

    // register map
    localparam addr_t ADDR_REFERENCE         = 8'h10;
    localparam addr_t ADDR_REFEN             = 8'h11;
    localparam addr_t ADDR_THRESHOLD         = 8'h12;
    localparam addr_t ADDR_STATUS            = 8'h13;
    localparam addr_t ADDR_MULTIPLE_TRIGGERS = 8'h14;

endpackage
